//--- hdl/cache_pkg.sv
// L1 data cache shared definitions
// geometry, address split, processor and memory bus structs,
// store command and lookup records, controller state encoding
package cache_pkg;

    // geometry with associativity fixed at two
    localparam int WORD_BITS   = 32;
    localparam int N_WAYS      = 2;
    localparam int N_SETS      = 8;
    localparam int BLOCK_WORDS = 2;
    localparam int SET_BITS    = 3;
    localparam int BLOCK_BITS  = 1;
    localparam int TAG_BITS    = WORD_BITS - SET_BITS - BLOCK_BITS - 2;
    localparam int BYTE_LANES  = 4;

    typedef logic [WORD_BITS-1:0] word_t;

    // byte address as seen by the cache
    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   set;
        logic [BLOCK_BITS-1:0] blk;      // word within block
        logic [1:0]            byte_off;
    } cache_addr_t;

    // processor request held until busy drops
    typedef struct packed {
        logic                  ren;
        logic                  wen;
        word_t                 addr;
        word_t                 wdata;
        logic [BYTE_LANES-1:0] byte_en;  // lanes in place, not shifted
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    // memory takes one word per non-busy cycle
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        NONE,
        WRITE_HIT,    // byte merge into hit word
        FILL_WORD,    // one refill beat
        FILL_DONE,    // last refill beat, frame becomes valid
        CLEAN_FRAME   // frame written back
    } store_op_e;

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FETCH,
        FLUSH_SCAN,
        FLUSH_WRITE
    } ctrl_state_e;

    // store answer for the current request address
    typedef struct packed {
        logic                hit;
        logic                hit_way;
        word_t               hit_word;
        logic                victim_way;
        logic                victim_dirty;
        logic [TAG_BITS-1:0] victim_tag;
    } lookup_t;

    // frame under the controller's scan pointer
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
        word_t               word;
    } scan_t;

    typedef struct packed {
        store_op_e             op;
        logic                  way;
        logic [SET_BITS-1:0]   set;
        logic [BLOCK_BITS-1:0] word;
        word_t                 data;
    } store_cmd_t;

endpackage

//--- hdl/cache_store.sv
// cache_store: tag, data, valid, dirty and LRU arrays of the L1 data cache
// does both-way tag compare, victim pick and byte-enable merge,
// applies the controller's update command on the next edge
`timescale 1ns/1ns

module cache_store (
    input  logic                              CLK,
    input  logic                              nRST,
    input  cache_pkg::cpu_req_t               req,
    input  cache_pkg::store_cmd_t             cmd,
    input  logic [cache_pkg::SET_BITS-1:0]    scan_set,
    input  logic                              scan_way,
    input  logic [cache_pkg::BLOCK_BITS-1:0]  scan_word,
    output cache_pkg::lookup_t                look,
    output cache_pkg::scan_t                  scan
);
    import cache_pkg::*;

    // frame storage
    word_t               data_q  [N_SETS][N_WAYS][BLOCK_WORDS];
    logic [TAG_BITS-1:0] tag_q   [N_SETS][N_WAYS];
    logic [N_WAYS-1:0]   valid_q [N_SETS];
    logic [N_WAYS-1:0]   dirty_q [N_SETS];
    logic [N_SETS-1:0]   lru_q;          // way most recently used, per set

    cache_addr_t       addr;
    logic [N_WAYS-1:0] way_hit;
    logic              hit_way;
    logic              victim_way;
    word_t             merged;

    assign addr = req.addr;

    // tag compare on both ways of the addressed set
    always_comb begin
        hit_way = 1'b0;
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = valid_q[addr.set][w] && (tag_q[addr.set][w] == addr.tag);
            if (way_hit[w]) begin
                hit_way = 1'(w);
            end
        end
    end

    assign victim_way = ~lru_q[addr.set];    // the way not used last

    always_comb begin
        look.hit          = |way_hit;
        look.hit_way      = hit_way;
        look.hit_word     = data_q[addr.set][hit_way][addr.blk];
        look.victim_way   = victim_way;
        look.victim_dirty = valid_q[addr.set][victim_way] & dirty_q[addr.set][victim_way];
        look.victim_tag   = tag_q[addr.set][victim_way];
    end

    // byte lanes from wdata where enabled, else keep the stored word
    always_comb begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            merged[8*b +: 8] = req.byte_en[b] ? req.wdata[8*b +: 8] : look.hit_word[8*b +: 8];
        end
    end

    // flush scan and write-back read port
    always_comb begin
        scan.valid = valid_q[scan_set][scan_way];
        scan.dirty = dirty_q[scan_set][scan_way];
        scan.tag   = tag_q[scan_set][scan_way];
        scan.word  = data_q[scan_set][scan_way][scan_word];
    end

    // data and tag arrays
    always_ff @(posedge CLK) begin
        case (cmd.op)
            WRITE_HIT: begin
                data_q[cmd.set][cmd.way][cmd.word] <= merged;
            end
            FILL_WORD: begin
                data_q[cmd.set][cmd.way][cmd.word] <= cmd.data;
            end
            FILL_DONE: begin
                data_q[cmd.set][cmd.way][cmd.word] <= cmd.data;  // final beat
                tag_q[cmd.set][cmd.way]            <= addr.tag;  // request still held
            end
            default: begin
            end
        endcase
    end

    // frame state and replacement bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else begin
            // read hit touches LRU without a command
            if (req.ren && look.hit) begin
                lru_q[addr.set] <= hit_way;
            end
            case (cmd.op)
                WRITE_HIT: begin
                    dirty_q[cmd.set][cmd.way] <= 1'b1;
                    lru_q[cmd.set]            <= cmd.way;
                end
                FILL_DONE: begin
                    valid_q[cmd.set][cmd.way] <= 1'b1;
                    dirty_q[cmd.set][cmd.way] <= 1'b0;
                end
                CLEAN_FRAME: begin
                    dirty_q[cmd.set][cmd.way] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // a refill never lands on a tag already present in the other way
    a_single_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (req.ren || req.wen) |-> $onehot0(way_hit));

endmodule

//--- hdl/cache_ctrl.sv
// cache_ctrl: miss, write-back and flush FSM of the L1 data cache
// answers hits in IDLE, refills on a miss after writing back a dirty
// victim, scans every (set, way) pair on flush and drives the memory bus
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                              CLK,
    input  logic                              nRST,
    input  cache_pkg::cpu_req_t               req,
    input  logic                              flush,
    input  cache_pkg::lookup_t                look,
    input  cache_pkg::scan_t                  scan,
    input  cache_pkg::mem_rsp_t               mem_rsp,
    output cache_pkg::cpu_rsp_t               rsp,
    output cache_pkg::mem_req_t               mem_req,
    output cache_pkg::store_cmd_t             cmd,
    output logic [cache_pkg::SET_BITS-1:0]    scan_set,
    output logic                              scan_way,
    output logic [cache_pkg::BLOCK_BITS-1:0]  scan_word,
    output logic                              flush_done
);
    import cache_pkg::*;

    ctrl_state_e           state_q, state_n;
    logic [BLOCK_BITS-1:0] word_q, word_n;   // beat within block
    logic [SET_BITS-1:0]   set_q, set_n;     // scan set, or miss set
    logic                  way_q, way_n;     // scan way, or victim way
    word_t                 base_q, base_n;   // block base for miss traffic
    logic                  done_q, done_n;

    cache_addr_t addr;
    logic        req_any;
    logic        last_word;
    logic        last_frame;
    logic        beat;

    assign addr       = req.addr;
    assign req_any    = req.ren | req.wen;
    assign last_word  = (word_q == BLOCK_BITS'(BLOCK_WORDS - 1));
    assign last_frame = (set_q == SET_BITS'(N_SETS - 1)) && (way_q == 1'(N_WAYS - 1));
    assign beat       = ~mem_rsp.busy;                 // memory took a word

    // store read pointer follows the counters
    assign scan_set   = set_q;
    assign scan_way   = way_q;
    assign scan_word  = word_q;
    assign flush_done = done_q;                        // first IDLE cycle after scan

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
            word_q  <= '0;
            set_q   <= '0;
            way_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_n;
            word_q  <= word_n;
            set_q   <= set_n;
            way_q   <= way_n;
            done_q  <= done_n;
        end
    end

    always_ff @(posedge CLK) begin
        base_q <= base_n;
    end

    always_comb begin
        state_n = state_q;
        word_n  = word_q;
        set_n   = set_q;
        way_n   = way_q;
        base_n  = base_q;
        done_n  = 1'b0;

        rsp.busy  = 1'b1;
        rsp.rdata = look.hit_word;

        mem_req       = '0;
        mem_req.addr  = {base_q[WORD_BITS-1:BLOCK_BITS+2], word_q, 2'b00};
        mem_req.wdata = scan.word;                      // victim or flushed frame

        cmd.op   = NONE;
        cmd.way  = way_q;
        cmd.set  = set_q;
        cmd.word = word_q;
        cmd.data = mem_rsp.rdata;

        case (state_q)
            IDLE: begin
                if (req_any) begin
                    if (look.hit) begin
                        rsp.busy = 1'b0;                // zero-wait hit
                        if (req.wen) begin
                            cmd.op   = WRITE_HIT;
                            cmd.way  = look.hit_way;
                            cmd.set  = addr.set;
                            cmd.word = addr.blk;
                        end
                    end else begin
                        set_n  = addr.set;              // pin the victim frame
                        way_n  = look.victim_way;
                        word_n = '0;
                        if (look.victim_dirty) begin
                            base_n  = {look.victim_tag, addr.set, BLOCK_BITS'(0), 2'b00};
                            state_n = WRITEBACK;
                        end else begin
                            base_n  = {addr.tag, addr.set, BLOCK_BITS'(0), 2'b00};
                            state_n = FETCH;
                        end
                    end
                end else if (flush && !done_q) begin   // no restart on the done cycle
                    set_n   = '0;
                    way_n   = 1'b0;
                    word_n  = '0;
                    state_n = FLUSH_SCAN;
                end
            end
            WRITEBACK: begin
                mem_req.wen = 1'b1;
                if (beat) begin
                    if (last_word) begin
                        cmd.op  = CLEAN_FRAME;
                        word_n  = '0;
                        base_n  = {addr.tag, addr.set, BLOCK_BITS'(0), 2'b00};
                        state_n = FETCH;
                    end else begin
                        word_n = word_q + 1'b1;
                    end
                end
            end
            FETCH: begin
                mem_req.ren = 1'b1;
                if (beat) begin
                    if (last_word) begin
                        cmd.op  = FILL_DONE;            // held request hits next cycle
                        word_n  = '0;
                        state_n = IDLE;
                    end else begin
                        cmd.op = FILL_WORD;
                        word_n = word_q + 1'b1;
                    end
                end
            end
            FLUSH_SCAN: begin
                if (scan.valid && scan.dirty) begin
                    state_n = FLUSH_WRITE;
                end else if (last_frame) begin
                    set_n   = '0;
                    way_n   = 1'b0;
                    done_n  = 1'b1;
                    state_n = IDLE;
                end else begin
                    {set_n, way_n} = {set_q, way_q} + 1'b1;   // way first, then set
                end
            end
            FLUSH_WRITE: begin
                mem_req.wen  = 1'b1;
                mem_req.addr = {scan.tag, set_q, word_q, 2'b00};
                if (beat) begin
                    if (last_word) begin
                        cmd.op  = CLEAN_FRAME;
                        word_n  = '0;
                        state_n = FLUSH_SCAN;            // rescan, now clean, then move on
                    end else begin
                        word_n = word_q + 1'b1;
                    end
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    a_mem_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen));

    // stalled beat keeps its address until accepted
    a_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_req.ren || mem_req.wen) && mem_rsp.busy) |=> $stable(mem_req.addr));

    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done);

endmodule

//--- hdl/l1_cache.sv
// l1_cache: two-way set-associative write-back L1 data cache
// store arrays plus miss and flush controller between the
// processor bus and the memory bus
`timescale 1ns/1ns

module l1_cache (
    input  logic                  CLK,
    input  logic                  nRST,
    input  cache_pkg::cpu_req_t   cpu_req,
    input  logic                  flush,
    output cache_pkg::cpu_rsp_t   cpu_rsp,
    output logic                  flush_done,
    output cache_pkg::mem_req_t   mem_req,
    input  cache_pkg::mem_rsp_t   mem_rsp
);
    import cache_pkg::*;

    lookup_t               look;       // hit and victim info for cpu_req
    scan_t                 scan;       // frame under the scan pointer
    store_cmd_t            cmd;        // array update, next edge
    logic [SET_BITS-1:0]   scan_set;
    logic                  scan_way;
    logic [BLOCK_BITS-1:0] scan_word;

    cache_store u_store (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (cpu_req),
        .cmd       (cmd),
        .scan_set  (scan_set),
        .scan_way  (scan_way),
        .scan_word (scan_word),
        .look      (look),
        .scan      (scan)
    );

    cache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (cpu_req),
        .flush      (flush),
        .look       (look),
        .scan       (scan),
        .mem_rsp    (mem_rsp),
        .rsp        (cpu_rsp),
        .mem_req    (mem_req),
        .cmd        (cmd),
        .scan_set   (scan_set),
        .scan_way   (scan_way),
        .scan_word  (scan_word),
        .flush_done (flush_done)
    );

endmodule

//--- sim/tb_mem_model.sv
// tb_mem_model: memory responder for the L1 cache testbench
// 64-word window, each beat stalls 0 to 3 random busy cycles,
// counts every accepted write per word and in total
`timescale 1ns/1ns

module tb_mem_model (
    input  logic                 CLK,
    input  logic                 nRST,
    input  cache_pkg::mem_req_t  mem_req,
    output cache_pkg::mem_rsp_t  mem_rsp
);
    import cache_pkg::*;

    localparam int MEM_WORDS = 64;

    word_t       mem    [MEM_WORDS];
    int unsigned wr_cnt [MEM_WORDS];   // accepted writes per word
    int unsigned wr_total;
    logic [1:0]  stall_q;              // busy cycles left before this beat
    logic [5:0]  idx;
    logic        active;

    assign idx    = mem_req.addr[7:2];  // word index inside the window
    assign active = mem_req.ren | mem_req.wen;

    // busy while idle or stalling and rdata straight from the array
    always_comb begin
        mem_rsp.busy  = !active || (stall_q != 2'd0);
        mem_rsp.rdata = mem[idx];
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i]    <= word_t'(i * 4) ^ 32'hA5A5_0000;  // byte address based
                wr_cnt[i] <= 0;
            end
            wr_total <= 0;
            stall_q  <= 2'd0;
        end else if (active) begin
            if (stall_q != 2'd0) begin
                stall_q <= stall_q - 2'd1;
            end else begin
                // beat accepted this edge
                if (mem_req.wen) begin
                    mem[idx]    <= mem_req.wdata;
                    wr_cnt[idx] <= wr_cnt[idx] + 1;
                    wr_total    <= wr_total + 1;
                end
                stall_q <= 2'($urandom % 4);   // stall for the next beat
            end
        end
    end

endmodule

//--- sim/tb_l1_cache.sv
// tb_l1_cache: testbench for the two-way write-back L1 data cache
// random reads and byte-enable writes checked against a flat model,
// LRU victim check and flush write-back check against memory
`timescale 1ns/1ns

module tb_l1_cache;
    import cache_pkg::*;

    localparam int WIN_WORDS = 64;     // 4 tags x 8 sets x 2 words
    localparam int N_OPS     = 400;
    localparam int TIMEOUT   = 200;    // cycles per wait loop

    logic     CLK;
    logic     nRST;
    logic     flush;
    logic     flush_done;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    word_t ref_mem [WIN_WORDS];        // processor view of every word

    l1_cache i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .flush      (flush),
        .cpu_rsp    (cpu_rsp),
        .flush_done (flush_done),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    tb_mem_model u_mem (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #2 CLK = ~CLK;              // 4 ns period

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // starts on a falling edge, returns on the falling edge after completion
    task automatic cpu_access(input logic wr, input int idx, input word_t wdata,
                              input logic [3:0] be, output word_t rdata);
        int cycles;
        cpu_req.ren     = !wr;
        cpu_req.wen     = wr;
        cpu_req.addr    = word_t'(idx * 4);
        cpu_req.wdata   = wdata;
        cpu_req.byte_en = be;
        cycles = 0;
        #1;
        while (cpu_rsp.busy) begin
            if (cycles >= TIMEOUT) begin
                stop_run($sformatf("timeout: request to word %0d never completed", idx));
            end
            @(negedge CLK);
            #1;
            cycles++;
        end
        rdata = cpu_rsp.rdata;         // valid in the completing cycle
        @(negedge CLK);
        cpu_req = '0;
    endtask

    task automatic read_check(input string name, input int idx);
        word_t got;
        cpu_access(1'b0, idx, '0, 4'b1111, got);
        check_word($sformatf("%s[%0d]", name, idx), ref_mem[idx], got);
    endtask

    task automatic write_word(input int idx, input word_t data, input logic [3:0] be);
        word_t ignored;
        cpu_access(1'b1, idx, data, be, ignored);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[idx][8*b +: 8] = data[8*b +: 8];   // model merge
            end
        end
    endtask

    // flush then expect one done pulse and a quiet tail
    task automatic run_flush(input string name);
        int cycles;
        flush  = 1'b1;
        cycles = 0;
        #1;
        while (!flush_done) begin
            if (cycles >= TIMEOUT) begin
                stop_run($sformatf("timeout: %s never raised flush_done", name));
            end
            @(negedge CLK);
            #1;
            cycles++;
        end
        @(negedge CLK);
        flush = 1'b0;
        for (int i = 0; i < 20; i++) begin
            #1;
            check_flag({name, "_single_done"}, 1'b0, flush_done);
            @(negedge CLK);
        end
    endtask

    function automatic logic [3:0] pick_byte_en();
        case ($urandom % 3)
            0:       return 4'b0001 << ($urandom % 4);            // one byte
            1:       return ($urandom % 2) ? 4'b1100 : 4'b0011;   // half word
            default: return 4'b1111;
        endcase
    endfunction

    initial begin
        int          idx;
        logic [3:0]  be;
        word_t       data;
        int unsigned cnt_a0;
        int unsigned cnt_a1;
        int unsigned cnt_b0;
        int unsigned cnt_b1;
        int unsigned total;

        CLK     = 1'b0;
        nRST    = 1'b0;
        flush   = 1'b0;
        cpu_req = '0;
        void'($urandom(92));
        for (int i = 0; i < WIN_WORDS; i++) begin
            ref_mem[i] = word_t'(i * 4) ^ 32'hA5A5_0000;
        end
        repeat (4) @(negedge CLK);
        nRST = 1'b1;

        // idle outputs after reset
        for (int i = 0; i < 4; i++) begin
            #1;
            check_flag("reset_mem_ren", 1'b0, mem_req.ren);
            check_flag("reset_mem_wen", 1'b0, mem_req.wen);
            check_flag("reset_flush_done", 1'b0, flush_done);
            check_flag("reset_cpu_busy", 1'b1, cpu_rsp.busy);
            @(negedge CLK);
        end

        // random traffic with each write read back at once
        for (int n = 0; n < N_OPS; n++) begin
            idx = $urandom % WIN_WORDS;
            if ($urandom % 2) begin
                be   = pick_byte_en();
                data = $urandom;
                write_word(idx, data, be);
                read_check("byte_merge", idx);
            end else begin
                read_check("random_read", idx);
            end
        end

        // LRU in set 5 with A tag 0, B tag 1 and C tag 2
        write_word(10, $urandom, 4'b1111);
        write_word(26, $urandom, 4'b1111);
        read_check("lru_touch_a", 10);
        cnt_a0 = u_mem.wr_cnt[10];
        cnt_a1 = u_mem.wr_cnt[11];
        cnt_b0 = u_mem.wr_cnt[26];
        cnt_b1 = u_mem.wr_cnt[27];
        write_word(42, $urandom, 4'b1111);       // evicts dirty B
        check_word("lru_wb_b0", word_t'(cnt_b0 + 1), word_t'(u_mem.wr_cnt[26]));
        check_word("lru_wb_b1", word_t'(cnt_b1 + 1), word_t'(u_mem.wr_cnt[27]));
        check_word("lru_keep_a0", word_t'(cnt_a0), word_t'(u_mem.wr_cnt[10]));
        check_word("lru_keep_a1", word_t'(cnt_a1), word_t'(u_mem.wr_cnt[11]));
        read_check("lru_read_a", 10);
        read_check("lru_read_b", 26);

        // more traffic to dirty frames before the flush
        for (int n = 0; n < 60; n++) begin
            idx = $urandom % WIN_WORDS;
            write_word(idx, $urandom, pick_byte_en());
        end
        run_flush("flush1");
        for (int i = 0; i < WIN_WORDS; i++) begin
            check_word($sformatf("flush_mem[%0d]", i), ref_mem[i], u_mem.mem[i]);
        end

        // nothing left dirty
        total = u_mem.wr_total;
        run_flush("flush2");
        check_word("flush2_writes", word_t'(total), word_t'(u_mem.wr_total));

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- all.f
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/l1_cache.sv
sim/tb_mem_model.sv
sim/tb_l1_cache.sv

//--- Makefile
# Verilator build and run for the L1 data cache testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_l1_cache
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
